/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_store_queue \
    -f src.f \
    -o sim_store_queue

./obj_dir/sim_store_queue > sim.log
cat sim.log

if grep -q "test passed" sim.log; then
    exit 0
fi
exit 1

/* sq_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_assertions
    import wb_pkg::*;
(
    input wire logic    clock,
    input wire logic    reset,
    input wire logic    alloc_en,
    input wire logic    retire_valid,
    input wire wb_m2s_t wb_out,
    input wire wb_s2m_t wb_in
);

    // allocated stores not yet retired
    int uncommitted;

    // assertion failures so far
    int failures = 0;

    always_ff @(posedge clock) begin
        if (reset) begin
            uncommitted <= 0;
        end else begin
            uncommitted <= uncommitted + (alloc_en ? 1 : 0) - (retire_valid ? 1 : 0);
        end
    end

    stb_inside_cyc: assert property (@(posedge clock) disable iff (reset)
        wb_out.stb |-> wb_out.cyc)
        else begin
            failures = failures + 1;
            $error("stb high without cyc");
        end

    // request fields frozen until the slave answers
    request_stable: assert property (@(posedge clock) disable iff (reset)
        (wb_out.stb && !wb_in.ack) |=> (wb_out.stb && $stable(wb_out.adr)
            && $stable(wb_out.dat) && $stable(wb_out.sel)))
        else begin
            failures = failures + 1;
            $error("wishbone request changed before ack");
        end

    retire_has_store: assert property (@(posedge clock) disable iff (reset)
        retire_valid |-> (uncommitted > 0))
        else begin
            failures = failures + 1;
            $error("retire with no uncommitted store");
        end

endmodule

`default_nettype wire

/* sq_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_checker
    import sq_types_pkg::*;
    import wb_pkg::*;
#(
    parameter int SQ_DEPTH = 8,
    localparam int IDX_W = $clog2(SQ_DEPTH),
    localparam int PTR_W = IDX_W + 1
) (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             dispatch_valid,
    input  wire logic             sq_full,
    input  wire logic [PTR_W-1:0] sq_tail,
    input  wire logic             resolve_valid,
    input  wire logic [IDX_W-1:0] resolve_idx,
    input  wire sq_entry_t        resolve_entry,
    input  wire logic             retire_valid,
    input  wire data_t            fwd_data,
    input  wire byte_mask_t       fwd_mask,
    input  wire wb_m2s_t          wb_out,
    input  wire wb_s2m_t          wb_in,
    // expected values from the stimulus table
    input  wire logic             exp_valid,
    input  wire logic             exp_is_load,
    input  wire logic [31:0]      exp_data,
    input  wire logic [3:0]       exp_mask,
    input  wire logic             exp_full,
    input  wire logic [PTR_W-1:0] exp_tail,
    output int                    errors,
    output int                    checks,
    output int                    pending_writes
);

    sq_entry_t        model_entry [SQ_DEPTH];
    logic [IDX_W-1:0] alloc_q [$];
    sq_entry_t        write_q [$];
    logic [PTR_W-1:0] model_tail;
    int               occupancy;
    logic             reset_d;

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] expv, inout bit ok);
        if (got !== expv) begin
            $display("Fail %s expected %h got %h", name, expv, got);
            ok = 1'b0;
        end
    endtask

    task automatic finish_test(input string what, input bit ok);
        checks = checks + 1;
        if (!ok) begin
            errors = errors + 1;
        end
        $display("%s %0d %s", what, checks, ok ? "ok" : "bad");
    endtask

    always @(posedge clock) begin
        bit               ok;
        bit               accept;
        sq_entry_t        head;
        logic [IDX_W-1:0] idx;
        if (reset) begin
            alloc_q.delete();
            write_q.delete();
            model_tail     = '0;
            occupancy      = 0;
            pending_writes = 0;
        end else begin
            // first cycle out of reset
            if (reset_d) begin
                ok = 1'b1;
                compare("cyc", 32'(wb_out.cyc), 32'h0, ok);
                compare("stb", 32'(wb_out.stb), 32'h0, ok);
                compare("sq_full", 32'(sq_full), 32'h0, ok);
                compare("sq_tail", 32'(sq_tail), 32'h0, ok);
                finish_test("reset", ok);
            end
            if (exp_valid) begin
                ok = 1'b1;
                if (exp_is_load) begin
                    compare("fwd_data", 32'(fwd_data), exp_data, ok);
                    compare("fwd_mask", 32'(fwd_mask), 32'(exp_mask), ok);
                    finish_test("load", ok);
                end else begin
                    compare("sq_full", 32'(sq_full), 32'(exp_full), ok);
                    compare("sq_tail", 32'(sq_tail), 32'(exp_tail), ok);
                    finish_test("state", ok);
                end
            end
            accept = dispatch_valid && (occupancy < SQ_DEPTH);
            if (wb_out.cyc && wb_out.stb && wb_in.ack) begin
                ok = 1'b1;
                if (write_q.size() == 0) begin
                    $display("a Wishbone write appeared with no retired store waiting");
                    ok = 1'b0;
                end else begin
                    head = write_q.pop_front();
                    compare("wb_out.we", 32'(wb_out.we), 32'h1, ok);
                    compare("wb_out.adr", 32'(wb_out.adr), 32'(head.addr), ok);
                    compare("wb_out.dat", wb_out.dat, 32'(head.data), ok);
                    compare("wb_out.sel", 32'(wb_out.sel), 32'(head.byte_mask), ok);
                    occupancy = occupancy - 1;
                end
                finish_test("write", ok);
            end
            if (accept) begin
                alloc_q.push_back(model_tail[IDX_W-1:0]);
                model_tail = model_tail + PTR_W'(1);
                occupancy  = occupancy + 1;
            end
            if (resolve_valid) begin
                model_entry[resolve_idx] = resolve_entry;
            end
            if (retire_valid) begin
                if (alloc_q.size() == 0) begin
                    $display("retire seen with no allocated store to commit");
                    errors = errors + 1;
                end else begin
                    idx = alloc_q.pop_front();
                    write_q.push_back(model_entry[idx]);
                end
            end
            pending_writes = write_q.size();
        end
        reset_d <= reset;
    end

    initial begin
        errors = 0;
        checks = 0;
    end

endmodule

`default_nettype wire

/* sq_drain_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_drain_fsm
    import sq_types_pkg::*;
    import wb_pkg::*;
(
    input  wire logic      clock,
    input  wire logic      reset,
    input  wire logic      commit_pending,
    input  wire sq_entry_t drain_entry,
    input  wire wb_s2m_t   wb_in,
    output wb_m2s_t        wb_out,
    output logic           drain_done
);

    typedef enum logic [1:0] {
        idle,
        write,
        gap
    } drain_state_t;

    drain_state_t state;

    // entry leaves the queue on the ack cycle
    assign drain_done = (state == write) && wb_in.ack;

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= idle;
            wb_out.cyc <= 1'b0;
            wb_out.stb <= 1'b0;
            wb_out.we  <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (commit_pending) begin
                        // latch the oldest committed store onto the bus
                        wb_out.cyc <= 1'b1;
                        wb_out.stb <= 1'b1;
                        wb_out.we  <= 1'b1;
                        wb_out.adr <= drain_entry.addr;
                        wb_out.dat <= drain_entry.data;
                        wb_out.sel <= drain_entry.byte_mask;
                        state      <= write;
                    end
                end
                write: begin
                    // everything held until the slave answers
                    if (wb_in.ack) begin
                        wb_out.cyc <= 1'b0;
                        wb_out.stb <= 1'b0;
                        wb_out.we  <= 1'b0;
                        state      <= gap;
                    end
                end
                gap: begin
                    // one idle bus cycle between writes
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* sq_entry_array.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_entry_array
    import sq_types_pkg::*;
#(
    parameter int SQ_DEPTH = 8,
    localparam int IDX_W = $clog2(SQ_DEPTH)
) (
    input  wire logic                   clock,
    input  wire logic                   reset,
    input  wire logic                   alloc_en,
    input  wire logic [IDX_W-1:0]       alloc_idx,
    input  wire logic                   resolve_valid,
    input  wire logic [IDX_W-1:0]       resolve_idx,
    input  wire sq_entry_t              resolve_entry,
    output sq_entry_t [SQ_DEPTH-1:0]    entries,
    output logic [SQ_DEPTH-1:0]         resolved
);

    // payload storage
    always_ff @(posedge clock) begin
        if (resolve_valid) begin
            entries[resolve_idx] <= resolve_entry;
        end
    end

    // resolved bits
    // a fresh allocation hides whatever the slot held before
    // resolve is applied last, so it wins on the same index
    always_ff @(posedge clock) begin
        if (reset) begin
            resolved <= '0;
        end else begin
            if (alloc_en) begin
                resolved[alloc_idx] <= 1'b0;
            end
            if (resolve_valid) begin
                resolved[resolve_idx] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* sq_forward.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_forward
    import sq_types_pkg::*;
#(
    parameter int SQ_DEPTH = 8,
    localparam int IDX_W = $clog2(SQ_DEPTH),
    localparam int PTR_W = IDX_W + 1
) (
    input  wire sq_entry_t [SQ_DEPTH-1:0] entries,
    input  wire logic [SQ_DEPTH-1:0]      resolved,
    input  wire logic [PTR_W-1:0]         drain_head,
    input  wire logic [PTR_W-1:0]         load_tail,
    input  wire word_addr_t               load_addr,
    output data_t                         fwd_data,
    output byte_mask_t                    fwd_mask
);

    // number of stores older than the load still in the queue
    logic [PTR_W-1:0] window_cnt;
    logic             window_ok;
    logic [IDX_W-1:0] tail_idx;

    assign window_cnt = load_tail - drain_head;
    assign tail_idx   = load_tail[IDX_W-1:0];

    // drain head already past the load tail, nothing older is left
    assign window_ok = (window_cnt <= PTR_W'(SQ_DEPTH));

    for (genvar lane = 0; lane < BYTES; lane++) begin : g_lane
        logic [SQ_DEPTH-1:0] match;
        logic [SQ_DEPTH-1:0] rot_match;
        logic                hit;
        logic [IDX_W-1:0]    sel_idx;

        // same word, lane written, data valid
        always_comb begin
            for (int j = 0; j < SQ_DEPTH; j++) begin
                match[j] = resolved[j]
                    && (entries[j].addr == load_addr)
                    && entries[j].byte_mask[lane];
            end
        end

        // rotate so load_tail sits at position 0
        // position SQ_DEPTH-1 is then the youngest older store
        always_comb begin
            logic [IDX_W-1:0] src;
            for (int k = 0; k < SQ_DEPTH; k++) begin
                src = tail_idx + IDX_W'(k);
                rot_match[k] = match[src]
                    && window_ok
                    && (PTR_W'(SQ_DEPTH - k) <= window_cnt);
            end
        end

        // highest set position wins
        always_comb begin
            hit     = 1'b0;
            sel_idx = '0;
            for (int k = 0; k < SQ_DEPTH; k++) begin
                if (rot_match[k]) begin
                    hit     = 1'b1;
                    sel_idx = tail_idx + IDX_W'(k);
                end
            end
        end

        assign fwd_data[lane] = hit ? entries[sel_idx].data[lane] : 8'h00;
        assign fwd_mask[lane] = hit;
    end

endmodule

`default_nettype wire

/* sq_pointers.sv */
`timescale 1ns/1ps
`default_nettype none

module sq_pointers #(
    parameter int SQ_DEPTH = 8,
    localparam int IDX_W = $clog2(SQ_DEPTH),
    localparam int PTR_W = IDX_W + 1
) (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             dispatch_valid,
    input  wire logic             retire_valid,
    input  wire logic             drain_done,
    output logic                  alloc_en,
    output logic [IDX_W-1:0]      alloc_idx,
    output logic [PTR_W-1:0]      sq_tail,
    output logic [PTR_W-1:0]      drain_head,
    output logic [IDX_W-1:0]      drain_idx,
    output logic                  commit_pending,
    output logic                  sq_full
);

    // oldest allocated entry not yet retired
    logic [PTR_W-1:0] commit_ptr;

    // allocated and not yet drained
    logic [PTR_W-1:0] occupancy;

    assign occupancy = sq_tail - drain_head;

    // tail and drain head equal except for the wrap bit
    assign sq_full = (occupancy == PTR_W'(SQ_DEPTH));

    // dispatch while full is dropped
    assign alloc_en  = dispatch_valid && !sq_full;
    assign alloc_idx = sq_tail[IDX_W-1:0];
    assign drain_idx = drain_head[IDX_W-1:0];

    // retired stores still waiting for the bus
    assign commit_pending = (commit_ptr != drain_head);

    always_ff @(posedge clock) begin
        if (reset) begin
            sq_tail <= '0;
        end else if (alloc_en) begin
            sq_tail <= sq_tail + PTR_W'(1);
        end
    end

    // one retire per cycle, in program order
    always_ff @(posedge clock) begin
        if (reset) begin
            commit_ptr <= '0;
        end else if (retire_valid) begin
            commit_ptr <= commit_ptr + PTR_W'(1);
        end
    end

    // frees the entry on the ack edge
    always_ff @(posedge clock) begin
        if (reset) begin
            drain_head <= '0;
        end else if (drain_done) begin
            drain_head <= drain_head + PTR_W'(1);
        end
    end

endmodule

`default_nettype wire

/* sq_types_pkg.sv */
`default_nettype none

package sq_types_pkg;

    // store data path widths
    localparam int DATA_W      = 32;
    localparam int BYTES       = DATA_W / 8;
    localparam int WORD_ADDR_W = 30;

    // word address, byte offset bits stripped
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;

    // store data seen as byte lanes
    typedef logic [BYTES-1:0][7:0] data_t;

    // one enable bit per byte lane
    typedef logic [BYTES-1:0] byte_mask_t;

    // one store queue entry, 66 bits
    typedef struct packed {
        word_addr_t addr;
        data_t      data;
        byte_mask_t byte_mask;
    } sq_entry_t;

endpackage

`default_nettype wire

/* src.f */
sq_types_pkg.sv
wb_pkg.sv
sq_pointers.sv
sq_entry_array.sv
sq_forward.sv
sq_drain_fsm.sv
store_queue_top.sv
sq_assertions.sv
sq_checker.sv
tb_store_queue.sv

/* store_queue_top.sv */
`timescale 1ns/1ps
`default_nettype none

module store_queue_top
    import sq_types_pkg::*;
    import wb_pkg::*;
#(
    parameter int SQ_DEPTH = 8,
    localparam int IDX_W = $clog2(SQ_DEPTH),
    localparam int PTR_W = IDX_W + 1
) (
    input  wire logic             clock,
    input  wire logic             reset,
    // dispatch
    input  wire logic             dispatch_valid,
    output logic                  sq_full,
    output logic [PTR_W-1:0]      sq_tail,
    // resolve
    input  wire logic             resolve_valid,
    input  wire logic [IDX_W-1:0] resolve_idx,
    input  wire sq_entry_t        resolve_entry,
    // retire
    input  wire logic             retire_valid,
    // load lookup
    input  wire word_addr_t       load_addr,
    input  wire logic [PTR_W-1:0] load_tail,
    output data_t                 fwd_data,
    output byte_mask_t            fwd_mask,
    // memory side
    output wb_m2s_t               wb_out,
    input  wire wb_s2m_t          wb_in
);

    logic                     alloc_en;
    logic [IDX_W-1:0]         alloc_idx;
    logic [PTR_W-1:0]         drain_head;
    logic [IDX_W-1:0]         drain_idx;
    logic                     commit_pending;
    logic                     drain_done;
    sq_entry_t [SQ_DEPTH-1:0] entries;
    logic [SQ_DEPTH-1:0]      resolved;
    sq_entry_t                drain_entry;

    // oldest undrained store feeds the bus master
    assign drain_entry = entries[drain_idx];

    sq_pointers #(.SQ_DEPTH(SQ_DEPTH)) u_pointers (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .retire_valid   (retire_valid),
        .drain_done     (drain_done),
        .alloc_en       (alloc_en),
        .alloc_idx      (alloc_idx),
        .sq_tail        (sq_tail),
        .drain_head     (drain_head),
        .drain_idx      (drain_idx),
        .commit_pending (commit_pending),
        .sq_full        (sq_full)
    );

    sq_entry_array #(.SQ_DEPTH(SQ_DEPTH)) u_entry_array (
        .clock         (clock),
        .reset         (reset),
        .alloc_en      (alloc_en),
        .alloc_idx     (alloc_idx),
        .resolve_valid (resolve_valid),
        .resolve_idx   (resolve_idx),
        .resolve_entry (resolve_entry),
        .entries       (entries),
        .resolved      (resolved)
    );

    sq_forward #(.SQ_DEPTH(SQ_DEPTH)) u_forward (
        .entries    (entries),
        .resolved   (resolved),
        .drain_head (drain_head),
        .load_tail  (load_tail),
        .load_addr  (load_addr),
        .fwd_data   (fwd_data),
        .fwd_mask   (fwd_mask)
    );

    sq_drain_fsm u_drain (
        .clock          (clock),
        .reset          (reset),
        .commit_pending (commit_pending),
        .drain_entry    (drain_entry),
        .wb_in          (wb_in),
        .wb_out         (wb_out),
        .drain_done     (drain_done)
    );

endmodule

`default_nettype wire

/* tb_store_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_store_queue
    import sq_types_pkg::*;
    import wb_pkg::*;
;

    localparam int SQ_DEPTH = 8;
    localparam int IDX_W    = $clog2(SQ_DEPTH);
    localparam int PTR_W    = IDX_W + 1;

    // row kinds
    localparam logic [2:0] K_STATE   = 3'd0;
    localparam logic [2:0] K_HOLD    = 3'd1;
    localparam logic [2:0] K_STORE   = 3'd2;
    localparam logic [2:0] K_DISP    = 3'd3;
    localparam logic [2:0] K_RESOLVE = 3'd4;
    localparam logic [2:0] K_RETIRE  = 3'd5;
    localparam logic [2:0] K_LOAD    = 3'd6;
    localparam logic [2:0] K_WAIT    = 3'd7;

    // flag means expected full, ack hold, or wait until idle
    typedef struct packed {
        logic [2:0]       kind;
        word_addr_t       addr;
        logic [31:0]      data;
        logic [3:0]       mask;
        logic [PTR_W-1:0] tail;
        logic             flag;
    } row_t;

    logic             clock;
    logic             reset;
    logic             dispatch_valid;
    logic             sq_full;
    logic [PTR_W-1:0] sq_tail;
    logic             resolve_valid;
    logic [IDX_W-1:0] resolve_idx;
    sq_entry_t        resolve_entry;
    logic             retire_valid;
    word_addr_t       load_addr;
    logic [PTR_W-1:0] load_tail;
    data_t            fwd_data;
    byte_mask_t       fwd_mask;
    wb_m2s_t          wb_out;
    wb_s2m_t          wb_in = '0;

    logic             exp_valid;
    logic             exp_is_load;
    logic [31:0]      exp_data;
    logic [3:0]       exp_mask;
    logic             exp_full;
    logic [PTR_W-1:0] exp_tail;
    int               errors;
    int               checks;
    int               pending_writes;

    logic             ack_hold;
    logic [31:0]      rng_state = 32'ha3562c4f;
    logic [1:0]       ack_wait = 2'd0;
    row_t             rows [$];
    int               cycle_count = 0;
    int               cycle_limit = 1000000;

    store_queue_top #(.SQ_DEPTH(SQ_DEPTH)) dut (.*);

    sq_checker #(.SQ_DEPTH(SQ_DEPTH)) u_checker (.*);

    bind store_queue_top sq_assertions u_assertions (
        .clock        (clock),
        .reset        (reset),
        .alloc_en     (alloc_en),
        .retire_valid (retire_valid),
        .wb_out       (wb_out),
        .wb_in        (wb_in)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // slave acks after 0 to 3 wait cycles unless held off
    always @(posedge clock) begin
        logic [31:0] nxt;
        nxt = xorshift32(rng_state);
        wb_in.ack <= 1'b0;
        if (wb_out.cyc && wb_out.stb && !wb_in.ack && !ack_hold && !reset) begin
            if (ack_wait == 2'd0) begin
                wb_in.ack <= 1'b1;
                rng_state <= nxt;
                ack_wait  <= nxt[1:0];
            end else begin
                ack_wait <= ack_wait - 2'd1;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("test failed");
            $finish;
        end
    end

    task automatic add_row(input logic [2:0] kind, input word_addr_t addr,
                           input logic [31:0] data, input logic [3:0] mask,
                           input logic [PTR_W-1:0] tail, input logic flag);
        rows.push_back('{kind, addr, data, mask, tail, flag});
    endtask

    task automatic build_table();
        add_row(K_STATE,   30'h0,   32'h0,        4'h0, 4'd0, 1'b0);
        add_row(K_HOLD,    30'h0,   32'h0,        4'h0, 4'd0, 1'b1);
        add_row(K_STORE,   30'h100, 32'h11223344, 4'hf, 4'd0, 1'b0);
        add_row(K_STORE,   30'h100, 32'haabbccdd, 4'h3, 4'd0, 1'b0);
        add_row(K_STORE,   30'h200, 32'h55667788, 4'hf, 4'd0, 1'b0);
        add_row(K_STORE,   30'h100, 32'h00ee0000, 4'h4, 4'd0, 1'b0);
        add_row(K_DISP,    30'h0,   32'h0,        4'h0, 4'd0, 1'b0);
        // youngest older store wins per lane
        add_row(K_LOAD,    30'h100, 32'h11eeccdd, 4'hf, 4'd5, 1'b0);
        add_row(K_LOAD,    30'h100, 32'h1122ccdd, 4'hf, 4'd3, 1'b0);
        add_row(K_LOAD,    30'h100, 32'h11223344, 4'hf, 4'd1, 1'b0);
        add_row(K_LOAD,    30'h100, 32'h0,        4'h0, 4'd0, 1'b0);
        add_row(K_LOAD,    30'h300, 32'h0,        4'h0, 4'd5, 1'b0);
        add_row(K_LOAD,    30'h200, 32'h55667788, 4'hf, 4'd5, 1'b0);
        // entry 4 still unresolved
        add_row(K_LOAD,    30'h400, 32'h0,        4'h0, 4'd5, 1'b0);
        add_row(K_RESOLVE, 30'h400, 32'hdeadbeef, 4'h9, 4'd4, 1'b0);
        add_row(K_LOAD,    30'h400, 32'hde0000ef, 4'h9, 4'd5, 1'b0);
        for (int i = 0; i < 5; i++) begin
            add_row(K_RETIRE, 30'h0, 32'h0, 4'h0, 4'd0, 1'b0);
        end
        // committed, bus held off
        add_row(K_LOAD,    30'h100, 32'h11eeccdd, 4'hf, 4'd5, 1'b0);
        add_row(K_STORE,   30'h500, 32'h01020304, 4'hf, 4'd0, 1'b0);
        add_row(K_STORE,   30'h100, 32'h77000000, 4'h8, 4'd0, 1'b0);
        add_row(K_STORE,   30'h600, 32'hcafef00d, 4'h6, 4'd0, 1'b0);
        add_row(K_STATE,   30'h0,   32'h0,        4'h0, 4'd8, 1'b1);
        add_row(K_DISP,    30'h0,   32'h0,        4'h0, 4'd0, 1'b0);
        add_row(K_STATE,   30'h0,   32'h0,        4'h0, 4'd8, 1'b1);
        add_row(K_LOAD,    30'h100, 32'h77eeccdd, 4'hf, 4'd8, 1'b0);
        add_row(K_HOLD,    30'h0,   32'h0,        4'h0, 4'd0, 1'b0);
        add_row(K_WAIT,    30'h0,   32'h0,        4'h0, 4'd0, 1'b0);
        add_row(K_STATE,   30'h0,   32'h0,        4'h0, 4'd8, 1'b0);
        for (int i = 0; i < 3; i++) begin
            add_row(K_RETIRE, 30'h0, 32'h0, 4'h0, 4'd0, 1'b0);
        end
        add_row(K_STORE,   30'h700, 32'h0badf00d, 4'hf, 4'd0, 1'b0);
        add_row(K_RETIRE,  30'h0,   32'h0,        4'h0, 4'd0, 1'b0);
        add_row(K_WAIT,    30'h0,   32'h0,        4'h0, 4'd0, 1'b1);
        add_row(K_STATE,   30'h0,   32'h0,        4'h0, 4'd9, 1'b0);
        // drained store is gone from the window
        add_row(K_LOAD,    30'h700, 32'h0,        4'h0, 4'd9, 1'b0);
    endtask

    task automatic wait_for_idle();
        @(negedge clock);
        while (pending_writes != 0 || wb_out.cyc) begin
            @(negedge clock);
        end
    endtask

    task automatic apply_row(input row_t r);
        logic [IDX_W-1:0] idx;
        @(negedge clock);
        idx = sq_tail[IDX_W-1:0];
        @(posedge clock);
        case (r.kind)
            K_STORE: begin
                dispatch_valid <= 1'b1;
                resolve_valid  <= 1'b1;
                resolve_idx    <= idx;
                resolve_entry  <= '{addr: r.addr, data: r.data, byte_mask: r.mask};
            end
            K_DISP: dispatch_valid <= 1'b1;
            K_RESOLVE: begin
                resolve_valid <= 1'b1;
                resolve_idx   <= r.tail[IDX_W-1:0];
                resolve_entry <= '{addr: r.addr, data: r.data, byte_mask: r.mask};
            end
            K_RETIRE: retire_valid <= 1'b1;
            K_LOAD: begin
                load_addr   <= r.addr;
                load_tail   <= r.tail;
                exp_valid   <= 1'b1;
                exp_is_load <= 1'b1;
                exp_data    <= r.data;
                exp_mask    <= r.mask;
            end
            K_STATE: begin
                exp_valid   <= 1'b1;
                exp_is_load <= 1'b0;
                exp_full    <= r.flag;
                exp_tail    <= r.tail;
            end
            K_HOLD: ack_hold <= r.flag;
            default: begin
                if (r.flag) begin
                    wait_for_idle();
                end else begin
                    @(negedge clock);
                    while (!wb_in.ack) begin
                        @(negedge clock);
                    end
                end
            end
        endcase
        @(posedge clock);
        dispatch_valid <= 1'b0;
        resolve_valid  <= 1'b0;
        retire_valid   <= 1'b0;
        exp_valid      <= 1'b0;
    endtask

    initial begin
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        resolve_valid  = 1'b0;
        resolve_idx    = '0;
        resolve_entry  = '0;
        retire_valid   = 1'b0;
        load_addr      = '0;
        load_tail      = '0;
        exp_valid      = 1'b0;
        exp_is_load    = 1'b0;
        exp_data       = '0;
        exp_mask       = '0;
        exp_full       = 1'b0;
        exp_tail       = '0;
        ack_hold       = 1'b0;
        build_table();
        cycle_limit = 20 * rows.size() + 200;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        wait_for_idle();
        repeat (2) @(negedge clock);
        if (pending_writes != 0) begin
            $display("missing write: %0d retired stores never reached the bus", pending_writes);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0 && pending_writes == 0 && dut.u_assertions.failures == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* wb_pkg.sv */
`default_nettype none

package wb_pkg;

    localparam int WB_ADR_W = 30;
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = WB_DAT_W / 8;

    // master to slave, classic cycle
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
        logic [WB_SEL_W-1:0] sel;
    } wb_m2s_t;

    // slave to master
    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_s2m_t;

endpackage

`default_nettype wire
